//--- design/aesRoundPkg.sv
`default_nettype none

package aesRoundPkg;

    ////////////////////////////////////////////////////////////
    // Block views
    ////////////////////////////////////////////////////////////

    // Byte r+4c is row r, column c
    // Word i carries bytes 4i..4i+3 with byte 4i in the low bits
    typedef union packed {
        logic [15:0][7:0] bytes;
        logic [3:0][31:0] words;
    } aesBlock_u;

    // Start request from the register file into the lanes
    typedef struct packed {
        logic      valid;
        aesBlock_u state;
        aesBlock_u key;
    } roundReq_t;

    // One substituted byte per lane
    typedef struct packed {
        logic       valid;
        logic [7:0] subByte;
    } laneOut_t;

    // Shifted block back to the register file
    typedef struct packed {
        logic      valid;
        aesBlock_u result;
    } roundRsp_t;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite map
    ////////////////////////////////////////////////////////////

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // Byte offsets with bits above 5 held at zero
    localparam logic [5:0] STATE_BASE  = 6'h00;
    localparam logic [5:0] KEY_BASE    = 6'h10;
    localparam logic [5:0] CTRL_ADDR   = 6'h20;
    localparam logic [5:0] STATUS_ADDR = 6'h24;
    localparam logic [5:0] RESULT_BASE = 6'h30;

endpackage

`default_nettype wire

//--- design/aesByteLane.sv
`default_nettype none

module aesByteLane import aesRoundPkg::*; (
    input  wire logic       clock,
    input  wire logic       arstN,
    input  wire logic       valid,
    input  wire logic [7:0] stateByte,
    input  wire logic [7:0] keyByte,
    output laneOut_t        out
);

    ////////////////////////////////////////////////////////////
    // GF(2^8) arithmetic modulo 0x11B
    ////////////////////////////////////////////////////////////

    // Shift and add multiply with reduction per step
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] shifted;
        acc     = '0;
        shifted = a;
        for (int bitIdx = 0; bitIdx < 8; bitIdx++) begin
            if (b[bitIdx]) begin
                acc = acc ^ shifted;
            end
            // xtime
            shifted = {shifted[6:0], 1'b0} ^ (shifted[7] ? 8'h1B : 8'h00);
        end
        gfMul = acc;
    endfunction

    // x^254 is the inverse, and zero stays zero
    function automatic logic [7:0] gfInverse(input logic [7:0] x);
        logic [7:0] power;
        logic [7:0] acc;
        power = x;
        acc   = 8'h01;
        // Product of x^2, x^4 ... x^128
        for (int step = 1; step < 8; step++) begin
            power = gfMul(power, power);
            acc   = gfMul(acc, power);
        end
        gfInverse = acc;
    endfunction

    // Affine map as the sum of four left rotations plus 0x63
    function automatic logic [7:0] affine(input logic [7:0] a);
        logic [7:0] rot1;
        logic [7:0] rot2;
        logic [7:0] rot3;
        logic [7:0] rot4;
        rot1   = {a[6:0], a[7]};
        rot2   = {a[5:0], a[7:6]};
        rot3   = {a[4:0], a[7:5]};
        rot4   = {a[3:0], a[7:4]};
        affine = a ^ rot1 ^ rot2 ^ rot3 ^ rot4 ^ 8'h63;
    endfunction

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    logic [7:0] keyed;
    logic [7:0] inverted;
    logic [7:0] substituted;

    // AddRoundKey
    assign keyed = stateByte ^ keyByte;

    // SubBytes
    assign inverted    = gfInverse(keyed);
    assign substituted = affine(inverted);

    // One cycle of latency
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            out <= '0;
        end else begin
            out.valid   <= valid;
            out.subByte <= substituted;
        end
    end

endmodule

`default_nettype wire

//--- design/aesRowShifter.sv
`default_nettype none

module aesRowShifter import aesRoundPkg::*; (
    input  wire logic clock,
    input  wire logic arstN,
    input  laneOut_t  lanes [16],
    output roundRsp_t rsp
);

    aesBlock_u shifted;

    ////////////////////////////////////////////////////////////
    // ShiftRows
    ////////////////////////////////////////////////////////////

    // Row r rotates left by r columns
    // result byte r+4c comes from lane r+4((c+r) mod 4)
    always_comb begin
        shifted = '0;
        for (int row = 0; row < 4; row++) begin
            for (int col = 0; col < 4; col++) begin
                shifted.bytes[row + 4 * col] =
                    lanes[row + 4 * ((col + row) % 4)].subByte;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    // Lanes run in lockstep, so lane 0 carries valid for all
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            rsp <= '0;
        end else begin
            rsp.valid  <= lanes[0].valid;
            rsp.result <= shifted;
        end
    end

endmodule

`default_nettype wire

//--- design/aesRegFile.sv
`default_nettype none

module aesRegFile import aesRoundPkg::*; #(
    parameter int addrWidth = 8
) (
    input  wire logic                 clock,
    input  wire logic                 arstN,
    // Write address and data
    input  wire logic [addrWidth-1:0] awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    input  wire logic [31:0]          wdata,
    input  wire logic                 wvalid,
    output logic                      wready,
    // Write response
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    // Read address
    input  wire logic [addrWidth-1:0] araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    // Read data
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire logic                 rready,
    // Round pipeline
    output roundReq_t                 req,
    input  roundRsp_t                 rsp
);

    // Upper bits zero, word aligned, and not in the 0x28..0x2F gap
    function automatic logic isMapped(input logic [addrWidth-1:0] addr);
        logic [5:0] offset;
        offset = addr[5:0];
        isMapped = ((addr >> 6) == '0) && (offset[1:0] == 2'b00)
                   && (offset[5:3] != 3'b101);
    endfunction

    aesBlock_u  stateReg;
    aesBlock_u  keyReg;
    aesBlock_u  resultReg;
    logic       done;
    logic       startPulse;

    logic       wrAccept;
    logic       wrMapped;
    logic [5:0] wrOffset;
    logic       rdAccept;
    logic       rdMapped;
    logic [5:0] rdOffset;
    logic [31:0] rdWord;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // AW and W taken together while no B is pending
    assign wrAccept = awvalid && wvalid && !bvalid;
    assign awready  = wrAccept;
    assign wready   = wrAccept;

    // One read in flight at most
    assign rdAccept = arvalid && !rvalid;
    assign arready  = rdAccept;

    assign wrOffset = awaddr[5:0];
    assign wrMapped = isMapped(awaddr);
    assign rdOffset = araddr[5:0];
    assign rdMapped = isMapped(araddr);

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            stateReg   <= '0;
            keyReg     <= '0;
            startPulse <= 1'b0;
            bvalid     <= 1'b0;
            bresp      <= RESP_OKAY;
        end else begin
            // Start lasts exactly one cycle
            startPulse <= wrAccept && wrMapped && (wrOffset == CTRL_ADDR) && wdata[0];
            if (wrAccept) begin
                bvalid <= 1'b1;
                bresp  <= wrMapped ? RESP_OKAY : RESP_SLVERR;
                if (wrMapped) begin
                    // Status and result writes fall through silently
                    if (wrOffset[5:4] == STATE_BASE[5:4]) begin
                        stateReg.words[wrOffset[3:2]] <= wdata;
                    end else if (wrOffset[5:4] == KEY_BASE[5:4]) begin
                        keyReg.words[wrOffset[3:2]] <= wdata;
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Sticky done where a new start wins over a finishing round
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            done      <= 1'b0;
            resultReg <= '0;
        end else begin
            if (wrAccept && wrMapped && (wrOffset == CTRL_ADDR) && wdata[0]) begin
                done <= 1'b0;
            end else if (rsp.valid) begin
                done <= 1'b1;
            end
            if (rsp.valid) begin
                resultReg <= rsp.result;
            end
        end
    end

    assign req.valid = startPulse;
    assign req.state = stateReg;
    assign req.key   = keyReg;

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    // Ctrl and unmapped offsets read as zero
    always_comb begin
        rdWord = '0;
        if (rdMapped) begin
            if (rdOffset[5:4] == STATE_BASE[5:4]) begin
                rdWord = stateReg.words[rdOffset[3:2]];
            end else if (rdOffset[5:4] == KEY_BASE[5:4]) begin
                rdWord = keyReg.words[rdOffset[3:2]];
            end else if (rdOffset == STATUS_ADDR) begin
                rdWord = {31'b0, done};
            end else if (rdOffset[5:4] == RESULT_BASE[5:4]) begin
                rdWord = resultReg.words[rdOffset[3:2]];
            end
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
            rdata  <= rdWord;
            rresp  <= rdMapped ? RESP_OKAY : RESP_SLVERR;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/aesRoundCore.sv
`default_nettype none

module aesRoundCore import aesRoundPkg::*; #(
    parameter int addrWidth = 8
) (
    input  wire logic                 clock,
    input  wire logic                 arstN,
    // AW and W
    input  wire logic [addrWidth-1:0] awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    input  wire logic [31:0]          wdata,
    input  wire logic                 wvalid,
    output logic                      wready,
    // B
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    // AR
    input  wire logic [addrWidth-1:0] araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    // R
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire logic                 rready
);

    roundReq_t req;
    roundRsp_t rsp;
    laneOut_t  laneOut [16];

    // AXI registers and start pulse
    aesRegFile #(
        .addrWidth(addrWidth)
    ) i_aesRegFile (
        .clock  (clock),
        .arstN  (arstN),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .req    (req),
        .rsp    (rsp)
    );

    // Sixteen byte lanes
    for (genvar laneIdx = 0; laneIdx < 16; laneIdx++) begin : gLane
        aesByteLane i_aesByteLane (
            .clock    (clock),
            .arstN    (arstN),
            .valid    (req.valid),
            .stateByte(req.state.bytes[laneIdx]),
            .keyByte  (req.key.bytes[laneIdx]),
            .out      (laneOut[laneIdx])
        );
    end

    // ShiftRows and result stage
    aesRowShifter i_aesRowShifter (
        .clock(clock),
        .arstN(arstN),
        .lanes(laneOut),
        .rsp  (rsp)
    );

endmodule

`default_nettype wire

//--- test/aesRoundCore_props.sv
`default_nettype none

module aesRoundCore_props import aesRoundPkg::*; #(
    parameter int addrWidth = 8
) (
    input wire logic                 clock,
    input wire logic                 arstN,
    input wire logic [addrWidth-1:0] awaddr,
    input wire logic                 awvalid,
    input wire logic                 awready,
    input wire logic [31:0]          wdata,
    input wire logic                 wvalid,
    input wire logic                 wready,
    input wire logic                 bvalid,
    input wire logic                 bready,
    input wire logic [addrWidth-1:0] araddr,
    input wire logic                 arvalid,
    input wire logic                 arready,
    input wire logic                 rvalid,
    input wire logic                 rready,
    input roundReq_t                 req,
    input roundRsp_t                 rsp
);

    ////////////////////////////////////////////////////////////
    // Master side holds valid and payload
    ////////////////////////////////////////////////////////////

    awHold: assert property (@(posedge clock) disable iff (!arstN)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW dropped or changed before awready");

    wHold: assert property (@(posedge clock) disable iff (!arstN)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W dropped or changed before wready");

    arHold: assert property (@(posedge clock) disable iff (!arstN)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR dropped or changed before arready");

    ////////////////////////////////////////////////////////////
    // Slave responses and round latency
    ////////////////////////////////////////////////////////////

    bHold: assert property (@(posedge clock) disable iff (!arstN)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clock) disable iff (!arstN)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Lane stage plus shifter stage
    roundLatency: assert property (@(posedge clock) disable iff (!arstN)
        rsp.valid == $past(req.valid, 2))
        else $error("rsp.valid not two cycles after req.valid");

endmodule

bind aesRoundCore aesRoundCore_props #(
    .addrWidth(addrWidth)
) i_aesRoundCoreProps (.*);

`default_nettype wire

//--- test/aesRoundCoreTb.sv
`default_nettype none

module aesRoundCoreTb import aesRoundPkg::*; ();

    localparam int addrWidth     = 8;
    localparam int timeoutCycles = 100;
    localparam int roundCount    = 50;
    localparam int maxPolls      = 20;
    localparam logic [31:0] lfsrSeed = 32'd79;
    // Maximal length taps in right shifting form
    localparam logic [31:0] lfsrTaps = 32'h80200003;

    logic                 clock;
    logic                 arstN;
    logic [addrWidth-1:0] awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [31:0]          wdata;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [addrWidth-1:0] araddr;
    logic                 arvalid;
    logic                 arready;
    logic [31:0]          rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;

    logic [31:0] lfsrState;
    logic [7:0]  sboxTable [256];
    int          checkCount;
    int          errorCount;
    logic        timedOut;

    aesRoundCore #(
        .addrWidth(addrWidth)
    ) i_aesRoundCore (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    // One LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? lfsrTaps : 32'h0);
        end
        randomBits = value;
    endfunction

    function automatic logic [addrWidth-1:0] regAddr(input logic [5:0] base, input int wordIdx);
        regAddr = addrWidth'(base) + addrWidth'(wordIdx * 4);
    endfunction

    // Carry-less product then long division by 0x11B
    function automatic logic [7:0] gfProduct(input logic [7:0] a, input logic [7:0] b);
        logic [14:0] wide;
        wide = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                wide = wide ^ (15'(a) << i);
            end
        end
        for (int i = 14; i >= 8; i--) begin
            if (wide[i]) begin
                wide = wide ^ (15'h11B << (i - 8));
            end
        end
        gfProduct = wide[7:0];
    endfunction

    // Inverse by exhaustive search with zero kept as zero
    function automatic logic [7:0] sboxEntry(input logic [7:0] x);
        logic [7:0] inverse;
        logic [7:0] mapped;
        inverse = 8'h00;
        for (int y = 1; y < 256; y++) begin
            if (gfProduct(x, 8'(y)) == 8'h01) begin
                inverse = 8'(y);
            end
        end
        // Bitwise affine form
        for (int i = 0; i < 8; i++) begin
            mapped[i] = inverse[i] ^ inverse[(i + 4) % 8] ^ inverse[(i + 5) % 8]
                        ^ inverse[(i + 6) % 8] ^ inverse[(i + 7) % 8];
        end
        sboxEntry = mapped ^ 8'h63;
    endfunction

    // AddRoundKey, SubBytes, ShiftRows
    function automatic aesBlock_u aesRoundModel(input aesBlock_u state, input aesBlock_u key);
        logic [7:0] sub [16];
        aesBlock_u  result;
        for (int i = 0; i < 16; i++) begin
            sub[i] = sboxTable[state.bytes[i] ^ key.bytes[i]];
        end
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                result.bytes[r + 4 * c] = sub[r + 4 * ((c + r) % 4)];
            end
        end
        aesRoundModel = result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and AXI tasks
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string signal, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", signal, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, timeoutCycles);
        errorCount++;
        timedOut = 1'b1;
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("Test %s: %s, %0d errors", name,
                 (errorCount == errorsBefore) ? "ok" : "FAILED", errorCount - errorsBefore);
    endtask

    task automatic axiWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int waitCycles;
        int delay;
        resp = 2'b11;
        @(posedge clock);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waitCycles = 0;
        @(negedge clock);
        while (!awready && waitCycles < timeoutCycles) begin
            @(negedge clock);
            waitCycles++;
        end
        if (!awready) begin
            reportTimeout("awready");
        end else begin
            // W is taken together with AW
            checkValue("wready", 32'(wready), 32'h1);
            // AW and W transfer on this edge
            @(posedge clock);
            #1;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            // Random B back-pressure
            delay = int'(randomBits(2));
            repeat (delay) begin
                @(posedge clock);
                #1;
            end
            bready = 1'b1;
            waitCycles = 0;
            @(negedge clock);
            while (!bvalid && waitCycles < timeoutCycles) begin
                @(negedge clock);
                waitCycles++;
            end
            if (!bvalid) begin
                reportTimeout("bvalid");
            end else begin
                resp = bresp;
                @(posedge clock);
                #1;
                bready = 1'b0;
            end
        end
    endtask

    task automatic axiRead(input logic [addrWidth-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp, output int acceptWait);
        int waitCycles;
        int delay;
        data = '1;
        resp = 2'b11;
        @(posedge clock);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        waitCycles = 0;
        @(negedge clock);
        while (!arready && waitCycles < timeoutCycles) begin
            @(negedge clock);
            waitCycles++;
        end
        acceptWait = waitCycles;
        if (!arready) begin
            reportTimeout("arready");
        end else begin
            @(posedge clock);
            #1;
            arvalid = 1'b0;
            // Random R back-pressure
            delay = int'(randomBits(2));
            repeat (delay) begin
                @(posedge clock);
                #1;
            end
            rready = 1'b1;
            waitCycles = 0;
            @(negedge clock);
            while (!rvalid && waitCycles < timeoutCycles) begin
                @(negedge clock);
                waitCycles++;
            end
            if (!rvalid) begin
                reportTimeout("rvalid");
            end else begin
                data = rdata;
                resp = rresp;
                @(posedge clock);
                #1;
                rready = 1'b0;
            end
        end
    endtask

    task automatic writeExpect(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                               input logic [1:0] expResp);
        logic [1:0] resp;
        axiWrite(addr, data, resp);
        checkValue($sformatf("bresp at 0x%h", addr), 32'(resp), 32'(expResp));
    endtask

    task automatic readExpect(input logic [addrWidth-1:0] addr, input logic [31:0] expData,
                              input logic [1:0] expResp);
        logic [31:0] data;
        logic [1:0]  resp;
        int          acceptWait;
        axiRead(addr, data, resp, acceptWait);
        checkValue($sformatf("rdata at 0x%h", addr), data, expData);
        checkValue($sformatf("rresp at 0x%h", addr), 32'(resp), 32'(expResp));
    endtask

    // Start write with a STATUS read issued right behind its transfer
    task automatic startAndProbe(output logic [31:0] statusData, output logic [1:0] statusResp,
                                 output int acceptWait);
        logic [1:0] ctrlResp;
        int         waitCycles;
        statusData = '1;
        statusResp = 2'b11;
        acceptWait = timeoutCycles;
        fork
            axiWrite(regAddr(CTRL_ADDR, 0), 32'h1, ctrlResp);
            begin
                waitCycles = 0;
                @(negedge clock);
                while (!(awvalid && awready) && waitCycles < timeoutCycles) begin
                    @(negedge clock);
                    waitCycles++;
                end
                if (!(awvalid && awready)) begin
                    reportTimeout("start write transfer");
                end else begin
                    axiRead(regAddr(STATUS_ADDR, 0), statusData, statusResp, acceptWait);
                end
            end
        join
        checkValue("bresp at CTRL", 32'(ctrlResp), 32'(RESP_OKAY));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        aesBlock_u   stateBlk;
        aesBlock_u   keyBlk;
        aesBlock_u   expected;
        logic [31:0] statusData;
        logic [1:0]  statusResp;
        logic [31:0] word;
        logic        doneSeen;
        int          acceptWait;
        int          polls;
        int          wordIdx;
        int          errorsBefore;
        arstN      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        checkCount = 0;
        errorCount = 0;
        timedOut   = 1'b0;
        lfsrState  = lfsrSeed;
        for (int x = 0; x < 256; x++) begin
            sboxTable[x] = sboxEntry(8'(x));
        end
        repeat (10) @(posedge clock);
        #1;
        arstN = 1'b1;

        // Everything zero out of reset
        errorsBefore = errorCount;
        readExpect(regAddr(STATUS_ADDR, 0), 32'h0, RESP_OKAY);
        for (int i = 0; i < 4; i++) begin
            readExpect(regAddr(STATE_BASE, i), 32'h0, RESP_OKAY);
            readExpect(regAddr(KEY_BASE, i), 32'h0, RESP_OKAY);
            readExpect(regAddr(RESULT_BASE, i), 32'h0, RESP_OKAY);
        end
        reportTest("1 reset values", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            stateBlk.words[i] = randomBits(32);
            keyBlk.words[i]   = randomBits(32);
            writeExpect(regAddr(STATE_BASE, i), stateBlk.words[i], RESP_OKAY);
            writeExpect(regAddr(KEY_BASE, i), keyBlk.words[i], RESP_OKAY);
        end
        for (int i = 0; i < 4; i++) begin
            readExpect(regAddr(STATE_BASE, i), stateBlk.words[i], RESP_OKAY);
            readExpect(regAddr(KEY_BASE, i), keyBlk.words[i], RESP_OKAY);
        end
        reportTest("2 state and key readback", errorsBefore);

        errorsBefore = errorCount;
        expected = '0;
        for (int n = 0; n < roundCount && !timedOut; n++) begin
            for (int i = 0; i < 4; i++) begin
                stateBlk.words[i] = randomBits(32);
                keyBlk.words[i]   = randomBits(32);
                writeExpect(regAddr(STATE_BASE, i), stateBlk.words[i], RESP_OKAY);
                writeExpect(regAddr(KEY_BASE, i), keyBlk.words[i], RESP_OKAY);
            end
            expected = aesRoundModel(stateBlk, keyBlk);
            startAndProbe(statusData, statusResp, acceptWait);
            checkValue("rresp at STATUS", 32'(statusResp), 32'(RESP_OKAY));
            // Round still in flight when the read is taken at once
            if (acceptWait == 0) begin
                checkValue("rdata at STATUS after start", statusData, 32'h0);
            end
            doneSeen = statusData[0];
            polls    = 0;
            while (!doneSeen && polls < maxPolls && !timedOut) begin
                axiRead(regAddr(STATUS_ADDR, 0), statusData, statusResp, acceptWait);
                doneSeen = statusData[0];
                polls++;
            end
            checkCount++;
            assert (doneSeen) else begin
                $display("Done flag still low after %0d status polls", maxPolls);
                errorCount++;
            end
            for (int i = 0; i < 4; i++) begin
                readExpect(regAddr(RESULT_BASE, i), expected.words[i], RESP_OKAY);
            end
        end
        reportTest("3 and 4 round results and done timing", errorsBefore);

        // Unmapped, misaligned and read-only offsets
        errorsBefore = errorCount;
        writeExpect(8'h28, randomBits(32), RESP_SLVERR);
        readExpect(8'h28, 32'h0, RESP_SLVERR);
        writeExpect(8'h01, randomBits(32), RESP_SLVERR);
        readExpect(regAddr(STATE_BASE, 0), stateBlk.words[0], RESP_OKAY);
        readExpect(8'h06, 32'h0, RESP_SLVERR);
        readExpect(8'h40, 32'h0, RESP_SLVERR);
        writeExpect(8'h50, randomBits(32), RESP_SLVERR);
        readExpect(regAddr(KEY_BASE, 0), keyBlk.words[0], RESP_OKAY);
        writeExpect(regAddr(RESULT_BASE, 1), randomBits(32), RESP_OKAY);
        readExpect(regAddr(RESULT_BASE, 1), expected.words[1], RESP_OKAY);
        writeExpect(regAddr(STATUS_ADDR, 0), 32'h0, RESP_OKAY);
        readExpect(regAddr(STATUS_ADDR, 0), 32'h1, RESP_OKAY);
        readExpect(regAddr(CTRL_ADDR, 0), 32'h0, RESP_OKAY);
        reportTest("5 unmapped and read-only offsets", errorsBefore);

        errorsBefore = errorCount;
        for (int n = 0; n < 20 && !timedOut; n++) begin
            wordIdx = int'(randomBits(2));
            word    = randomBits(32);
            writeExpect(regAddr(KEY_BASE, wordIdx), word, RESP_OKAY);
            readExpect(regAddr(KEY_BASE, wordIdx), word, RESP_OKAY);
            readExpect(regAddr(RESULT_BASE, wordIdx), expected.words[wordIdx], RESP_OKAY);
        end
        reportTest("6 B and R back-pressure", errorsBefore);

        $display("Total checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Ends the run on the first timeout
    initial begin
        @(posedge timedOut);
        $display("Total checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- aesRoundCore.f
design/aesRoundPkg.sv
design/aesByteLane.sv
design/aesRowShifter.sv
design/aesRegFile.sv
design/aesRoundCore.sv
test/aesRoundCore_props.sv
test/aesRoundCoreTb.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module aesRoundCoreTb \
    -f aesRoundCore.f -Mdir obj_dir -o aesRoundCoreSim

if ! ./obj_dir/aesRoundCoreSim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
